/* calc_pkg.sv */
package calc_pkg;

    // datapath
    localparam int DATA_W = 16;                     // entry and result width
    localparam int MUL_CNT_W = $clog2(DATA_W);      // shift-add step counter
    localparam logic [MUL_CNT_W-1:0] MUL_LAST = MUL_CNT_W'(DATA_W - 1);

    // keypad debounce
    localparam int DEBOUNCE_CYCLES = 10;            // low cycles before accept
    localparam int DEB_CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [DEB_CNT_W-1:0] DEB_LAST = DEB_CNT_W'(DEBOUNCE_CYCLES - 1);

    // operator codes, shared by keypad, controller and alu
    typedef enum logic [2:0] {
        OP_NONE = 3'b000,
        OP_NEG  = 3'b001,                           // D key, acts on entry
        OP_ADD  = 3'b010,                           // A key
        OP_SUB  = 3'b011,                           // B key
        OP_MUL  = 3'b100                            // C key
    } op_t;

    // key position = row * 4 + column
    //   row 0: 1 2 3 A
    //   row 1: 4 5 6 B
    //   row 2: 7 8 9 C
    //   row 3: * 0 # D
    typedef logic [3:0] key_pos_t;

    localparam key_pos_t KEY_ADD   = 4'd3;          // A
    localparam key_pos_t KEY_SUB   = 4'd7;          // B
    localparam key_pos_t KEY_MUL   = 4'd11;         // C
    localparam key_pos_t KEY_EQUAL = 4'd12;         // *
    localparam key_pos_t KEY_ZERO  = 4'd13;         // 0
    localparam key_pos_t KEY_HASH  = 4'd14;         // #, ignored by controller
    localparam key_pos_t KEY_NEG   = 4'd15;         // D

    // digit field value for keys that carry no digit
    localparam logic [3:0] NO_DIGIT = 4'hF;

endpackage

/* keypad_scanner.sv */
module keypad_scanner (
    input  logic             clk,
    input  logic             nRST,
    input  logic [3:0]       row_in,        // pulled up and low when pressed
    output logic [3:0]       col_out,       // one column driven low
    output logic             key_req,       // key event offered
    input  logic             key_ack,       // controller done with key
    output logic [3:0]       key_digit,     // 0..9 or NO_DIGIT
    output calc_pkg::op_t    key_op,        // operator or negate
    output logic             key_equal      // '*' key
);

    typedef enum logic [2:0] {
        S_IDLE,                             // wait for ack low
        S_SCAN,                             // walk columns
        S_DEBOUNCE,                         // count low cycles on a frozen column
        S_OFFER,                            // req high until ack
        S_RELEASE                           // wait for key up after ack
    } state_t;

    state_t                          state;
    logic [1:0]                      col_idx;
    logic [calc_pkg::DEB_CNT_W-1:0]  deb_cnt;
    logic                            any_low;
    logic                            accept;
    calc_pkg::key_pos_t              pos_now;

    // lowest low row wins and position is {row, col}
    function automatic calc_pkg::key_pos_t encode_key(input logic [3:0] rows,
                                                      input logic [1:0] col);
        logic [1:0] r;
        casez (rows)
            4'b???0: r = 2'd0;
            4'b??01: r = 2'd1;
            4'b?011: r = 2'd2;
            default: r = 2'd3;
        endcase
        return {r, col};
    endfunction

    assign any_low = ~&row_in;               // some row pulled low
    assign pos_now = encode_key(row_in, col_idx);
    assign accept  = (state == S_DEBOUNCE) && any_low
                     && (deb_cnt == calc_pkg::DEB_LAST); // 10th low cycle

    always_comb begin
        col_out = 4'b1111;
        col_out[col_idx] = 1'b0;             // active column low
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= S_IDLE;
            col_idx <= 2'd0;
            deb_cnt <= '0;
            key_req <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!key_ack) state <= S_SCAN; // previous handshake closed
                end
                S_SCAN: begin
                    if (any_low) begin
                        deb_cnt <= calc_pkg::DEB_CNT_W'(1); // first low cycle
                        state   <= S_DEBOUNCE;
                    end else begin
                        col_idx <= col_idx + 2'd1;  // wraps after column 3
                    end
                end
                S_DEBOUNCE: begin
                    if (!any_low) begin
                        deb_cnt <= '0;      // bounce restarts the count
                        state   <= S_SCAN;
                    end else if (accept) begin
                        key_req <= 1'b1;
                        state   <= S_OFFER;
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
                S_OFFER: begin
                    if (key_ack) state <= S_RELEASE;
                end
                S_RELEASE: begin
                    if (!any_low) begin     // close request on key up
                        key_req <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // key fields loaded once per accepted press
    always_ff @(posedge clk) begin
        if (accept) begin
            key_digit <= calc_pkg::NO_DIGIT;
            key_op    <= calc_pkg::OP_NONE;
            key_equal <= 1'b0;
            case (pos_now)
                4'd0:                key_digit <= 4'd1;
                4'd1:                key_digit <= 4'd2;
                4'd2:                key_digit <= 4'd3;
                4'd4:                key_digit <= 4'd4;
                4'd5:                key_digit <= 4'd5;
                4'd6:                key_digit <= 4'd6;
                4'd8:                key_digit <= 4'd7;
                4'd9:                key_digit <= 4'd8;
                4'd10:               key_digit <= 4'd9;
                calc_pkg::KEY_ZERO:  key_digit <= 4'd0;
                calc_pkg::KEY_ADD:   key_op    <= calc_pkg::OP_ADD;
                calc_pkg::KEY_SUB:   key_op    <= calc_pkg::OP_SUB;
                calc_pkg::KEY_MUL:   key_op    <= calc_pkg::OP_MUL;
                calc_pkg::KEY_NEG:   key_op    <= calc_pkg::OP_NEG;
                calc_pkg::KEY_EQUAL: key_equal <= 1'b1;
                default: ;                   // '#' keeps all fields empty
            endcase
        end
    end

    // a low row freezes the column
    a_col_freeze: assert property (@(posedge clk) disable iff (!nRST)
        any_low |=> $stable(col_out));

    // request held until the controller has answered
    a_req_hold: assert property (@(posedge clk) disable iff (!nRST)
        key_req && !key_ack |=> key_req);

endmodule

/* calc_alu.sv */
module calc_alu (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        alu_start,  // one-cycle pulse
    input  calc_pkg::op_t               alu_op,
    input  logic [calc_pkg::DATA_W-1:0] alu_a,
    input  logic [calc_pkg::DATA_W-1:0] alu_b,      // negate operand
    output logic                        alu_done,   // one-cycle pulse
    output logic [calc_pkg::DATA_W-1:0] alu_y
);

    logic                                busy;      // multiply in progress
    logic [calc_pkg::MUL_CNT_W-1:0]      mul_cnt;
    logic [calc_pkg::DATA_W-1:0]         mcand;     // shifted left each step
    logic [calc_pkg::DATA_W-1:0]         mplier;    // shifted right each step
    logic [calc_pkg::DATA_W-1:0]         prod;      // low half of product
    logic [calc_pkg::DATA_W-1:0]         prod_next;

    assign prod_next = mplier[0] ? prod + mcand : prod;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            mul_cnt  <= '0;
            alu_done <= 1'b0;
        end else begin
            alu_done <= 1'b0;
            if (alu_start && alu_op == calc_pkg::OP_MUL) begin
                busy    <= 1'b1;
                mul_cnt <= '0;
            end else if (alu_start) begin
                alu_done <= 1'b1;           // single-cycle ops
            end else if (busy) begin
                mul_cnt <= mul_cnt + 1'b1;
                if (mul_cnt == calc_pkg::MUL_LAST) begin
                    busy     <= 1'b0;
                    alu_done <= 1'b1;       // DATA_W+1 cycles after start
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            case (alu_op)
                calc_pkg::OP_ADD: alu_y <= alu_a + alu_b;
                calc_pkg::OP_SUB: alu_y <= alu_a - alu_b;
                calc_pkg::OP_NEG: alu_y <= ~alu_b + 1'b1;  // two's complement
                calc_pkg::OP_MUL: begin
                    mcand  <= alu_a;
                    mplier <= alu_b;
                    prod   <= '0;
                end
                default: alu_y <= alu_b;    // no operator, pass operand
            endcase
        end else if (busy) begin
            prod   <= prod_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (mul_cnt == calc_pkg::MUL_LAST) alu_y <= prod_next;
        end
    end

    // controller waits for done before the next start
    a_no_start_busy: assert property (@(posedge clk) disable iff (!nRST)
        alu_start |-> !busy);

endmodule

/* calc_controller.sv */
module calc_controller (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        key_req,
    output logic                        key_ack,
    input  logic [3:0]                  key_digit,
    input  calc_pkg::op_t               key_op,
    input  logic                        key_equal,
    output logic                        alu_start,
    output calc_pkg::op_t               alu_op,
    output logic [calc_pkg::DATA_W-1:0] alu_a,
    output logic [calc_pkg::DATA_W-1:0] alu_b,
    input  logic                        alu_done,
    input  logic [calc_pkg::DATA_W-1:0] alu_y,
    output logic [calc_pkg::DATA_W-1:0] display_value,
    output logic [calc_pkg::DATA_W-1:0] result,
    output logic                        result_valid
);

    typedef enum logic [1:0] {
        C_IDLE,                             // wait for key_req
        C_ALU,                              // wait for alu_done
        C_ACK                               // ack high, wait req low
    } state_t;

    state_t                        state;
    logic [calc_pkg::DATA_W-1:0]   entry;       // number being typed
    logic [calc_pkg::DATA_W-1:0]   acc;         // left operand
    calc_pkg::op_t                 pending;     // operator waiting for entry
    logic                          loaded;      // acc holds an operand
    logic                          show_result;
    logic [calc_pkg::DATA_W-1:0]   entry_next;
    logic                          is_digit;
    logic                          is_neg;
    logic                          is_binop;

    // entry * 10 + digit, as (entry << 3) + (entry << 1)
    assign entry_next = (entry << 3) + (entry << 1)
                        + {{(calc_pkg::DATA_W-4){1'b0}}, key_digit};
    assign is_digit = (key_digit <= 4'd9);      // '#' carries NO_DIGIT
    assign is_neg   = (key_op == calc_pkg::OP_NEG);
    assign is_binop = (key_op == calc_pkg::OP_ADD) || (key_op == calc_pkg::OP_SUB)
                      || (key_op == calc_pkg::OP_MUL);

    assign display_value = show_result ? result : entry;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= C_IDLE;
            key_ack      <= 1'b0;
            alu_start    <= 1'b0;
            entry        <= '0;
            acc          <= '0;
            pending      <= calc_pkg::OP_NONE;
            loaded       <= 1'b0;
            show_result  <= 1'b0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            alu_start    <= 1'b0;           // pulses
            result_valid <= 1'b0;
            case (state)
                C_IDLE: if (key_req) begin
                    if (key_equal && pending == calc_pkg::OP_NONE) begin
                        result       <= entry;  // nothing pending
                        result_valid <= 1'b1;
                        show_result  <= 1'b1;
                        entry        <= '0;
                        acc          <= '0;
                        loaded       <= 1'b0;
                        key_ack      <= 1'b1;
                        state        <= C_ACK;
                    end else if (key_equal || is_neg || (is_binop && loaded)) begin
                        alu_start <= 1'b1;      // operands set below
                        state     <= C_ALU;
                    end else if (is_binop) begin
                        acc     <= entry;       // first operand
                        pending <= key_op;
                        loaded  <= 1'b1;
                        entry   <= '0;
                        key_ack <= 1'b1;
                        state   <= C_ACK;
                    end else begin
                        if (is_digit) begin
                            entry       <= entry_next;
                            show_result <= 1'b0;
                        end
                        key_ack <= 1'b1;        // digit or '#'
                        state   <= C_ACK;
                    end
                end
                C_ALU: if (alu_done) begin
                    if (key_equal) begin
                        result       <= alu_y;
                        result_valid <= 1'b1;   // same cycle as ack
                        show_result  <= 1'b1;
                        entry        <= '0;
                        acc          <= '0;
                        pending      <= calc_pkg::OP_NONE;
                        loaded       <= 1'b0;
                    end else if (is_neg) begin
                        entry <= alu_y;
                    end else begin
                        acc     <= alu_y;       // running total
                        pending <= key_op;
                        entry   <= '0;
                    end
                    key_ack <= 1'b1;
                    state   <= C_ACK;
                end
                C_ACK: if (!key_req) begin
                    key_ack <= 1'b0;
                    state   <= C_IDLE;
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // alu operands, captured with the start pulse
    always_ff @(posedge clk) begin
        if (state == C_IDLE && key_req) begin
            alu_op <= is_neg ? calc_pkg::OP_NEG : pending;
            alu_a  <= acc;
            alu_b  <= entry;
        end
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!nRST)
        $rose(key_ack) |-> key_req);

endmodule

/* calc_top.sv */
module calc_top (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [3:0]                  row_in,         // keypad rows
    output logic [3:0]                  col_out,        // keypad columns
    output logic [calc_pkg::DATA_W-1:0] display_value,
    output logic [calc_pkg::DATA_W-1:0] result,
    output logic                        result_valid    // end of an equal key
);

    // scanner to controller
    logic                        key_req;
    logic                        key_ack;
    logic [3:0]                  key_digit;
    calc_pkg::op_t               key_op;
    logic                        key_equal;

    // controller to alu
    logic                        alu_start;
    calc_pkg::op_t               alu_op;
    logic [calc_pkg::DATA_W-1:0] alu_a;
    logic [calc_pkg::DATA_W-1:0] alu_b;
    logic                        alu_done;
    logic [calc_pkg::DATA_W-1:0] alu_y;

    keypad_scanner u_scanner (
        .clk(clk), .nRST(nRST),
        .row_in(row_in), .col_out(col_out),
        .key_req(key_req), .key_ack(key_ack),
        .key_digit(key_digit), .key_op(key_op), .key_equal(key_equal)
    );

    calc_controller u_ctrl (
        .clk(clk), .nRST(nRST),
        .key_req(key_req), .key_ack(key_ack),
        .key_digit(key_digit), .key_op(key_op), .key_equal(key_equal),
        .alu_start(alu_start), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_done(alu_done), .alu_y(alu_y),
        .display_value(display_value), .result(result), .result_valid(result_valid)
    );

    calc_alu u_alu (
        .clk(clk), .nRST(nRST),
        .alu_start(alu_start), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_done(alu_done), .alu_y(alu_y)
    );

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic nRST
);

    localparam int HALF_PERIOD  = 4;        // period 8
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;                        // released on a falling edge
    end

endmodule

/* keypad_model.sv */
module keypad_model (
    input  logic               clk,
    input  logic [3:0]         col_out,     // scanned column, active low
    input  logic               key_down,    // finger on the key
    input  calc_pkg::key_pos_t key_pos,     // {row, col} of the key
    output logic [3:0]         row_in       // pulled up, low on contact
);

    localparam int BOUNCE_LEN = 5;          // toggles after first touch

    logic contact    = 1'b0;                // switch closed
    logic down_q     = 1'b0;
    int   bounce_cnt = 0;

    // contact chatters for a few cycles on each press, release is clean
    always @(posedge clk) begin
        down_q <= key_down;
        if (key_down && !down_q) begin
            contact    <= 1'b1;
            bounce_cnt <= BOUNCE_LEN;
        end else if (bounce_cnt != 0) begin
            contact    <= ~contact;
            bounce_cnt <= bounce_cnt - 1;
        end else begin
            contact <= key_down;
        end
    end

    // row only pulled low while its column is driven
    always_comb begin
        row_in = 4'b1111;
        if (contact && !col_out[key_pos[1:0]]) row_in[key_pos[3:2]] = 1'b0;
    end

endmodule

/* calc_tb.sv */
module calc_tb;

    localparam int NORMAL_HOLD = 56;        // bounce + scan + debounce + multiply
    localparam int SHORT_HOLD  = 12;        // steady part below debounce length
    localparam int LONG_HOLD   = 200;
    localparam int GAP         = 8;         // released cycles between keys
    localparam int MAX_ROWS    = 20;
    localparam int N_RANDOM    = 4;

    logic                        clk;
    logic                        nRST;
    logic [3:0]                  row_in;
    logic [3:0]                  col_out;
    logic [calc_pkg::DATA_W-1:0] display_value;
    logic [calc_pkg::DATA_W-1:0] result;
    logic                        result_valid;
    logic                        key_down;
    calc_pkg::key_pos_t          key_pos;

    // key table of sequence, per-key hold code (n/s/l) and expected result
    string                       seq_tbl  [MAX_ROWS];
    string                       hold_tbl [MAX_ROWS];
    logic [calc_pkg::DATA_W-1:0] exp_tbl  [MAX_ROWS];
    int                          n_rows    = 0;
    int                          errors    = 0;
    int                          checks    = 0;
    int                          res_count = 0;    // result_valid pulses seen
    logic [calc_pkg::DATA_W-1:0] res_seen  = '0;
    int                          wd_cycles = 0;
    logic                        table_ready = 1'b0;

    // reference calculator state
    logic [calc_pkg::DATA_W-1:0] m_entry;
    logic [calc_pkg::DATA_W-1:0] m_acc;
    logic [calc_pkg::DATA_W-1:0] m_result;
    byte                         m_pending;        // 0, "A", "B" or "C"
    logic                        m_loaded;
    logic                        m_show_res;

    tb_clock_gen clk_gen_i (.clk(clk), .nRST(nRST));

    keypad_model keypad_i (
        .clk(clk), .col_out(col_out), .key_down(key_down), .key_pos(key_pos),
        .row_in(row_in)
    );

    calc_top dut_i (
        .clk(clk), .nRST(nRST), .row_in(row_in), .col_out(col_out),
        .display_value(display_value), .result(result), .result_valid(result_valid)
    );

    always @(negedge clk) begin
        if (nRST && result_valid) begin   // result stable mid-cycle
            res_count <= res_count + 1;
            res_seen  <= result;
        end
    end

    task automatic check(input string name, input logic [calc_pkg::DATA_W-1:0] got,
                         input logic [calc_pkg::DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic add_row(input string s, input string h,
                           input logic [calc_pkg::DATA_W-1:0] e);
        seq_tbl[n_rows]  = s;
        hold_tbl[n_rows] = h;
        exp_tbl[n_rows]  = e;
        n_rows++;
    endtask

    function automatic logic [calc_pkg::DATA_W-1:0] apply_op(input byte op,
        input logic [calc_pkg::DATA_W-1:0] a, input logic [calc_pkg::DATA_W-1:0] b);
        case (op)
            "A":     return a + b;
            "B":     return a - b;
            "C":     return a * b;           // low 16 bits kept
            default: return b;
        endcase
    endfunction

    // one accepted key applied to the reference state
    task automatic model_step(input byte ch);
        if (ch >= "0" && ch <= "9") begin
            m_entry    = m_entry * 16'd10 + 16'(ch - "0");
            m_show_res = 1'b0;
        end else if (ch == "D") begin
            m_entry = -m_entry;              // negate acts at once
        end else if (ch == "A" || ch == "B" || ch == "C") begin
            m_acc     = m_loaded ? apply_op(m_pending, m_acc, m_entry) : m_entry;
            m_loaded  = 1'b1;
            m_pending = ch;
            m_entry   = '0;
        end else if (ch == "*") begin
            m_result   = (m_pending == 0) ? m_entry : apply_op(m_pending, m_acc, m_entry);
            m_show_res = 1'b1;
            m_entry    = '0;
            m_acc      = '0;
            m_pending  = 0;
            m_loaded   = 1'b0;
        end                                  // '#' does nothing
    endtask

    function automatic calc_pkg::key_pos_t char_to_pos(input byte ch);
        case (ch)
            "1": return 4'd0;
            "2": return 4'd1;
            "3": return 4'd2;
            "A": return calc_pkg::KEY_ADD;
            "4": return 4'd4;
            "5": return 4'd5;
            "6": return 4'd6;
            "B": return calc_pkg::KEY_SUB;
            "7": return 4'd8;
            "8": return 4'd9;
            "9": return 4'd10;
            "C": return calc_pkg::KEY_MUL;
            "*": return calc_pkg::KEY_EQUAL;
            "0": return calc_pkg::KEY_ZERO;
            "D": return calc_pkg::KEY_NEG;
            "#": return calc_pkg::KEY_HASH;
            default: begin
                errors++;
                $display("unknown key character '%c' in the key table", ch);
                return calc_pkg::KEY_HASH;
            end
        endcase
    endfunction

    function automatic int hold_cycles(input byte code);
        return (code == "s") ? SHORT_HOLD : (code == "l") ? LONG_HOLD : NORMAL_HOLD;
    endfunction

    task automatic press_key(input byte ch, input int hold);
        @(negedge clk);
        key_pos  = char_to_pos(ch);
        key_down = 1'b1;
        repeat (hold) @(negedge clk);
        key_down = 1'b0;
        repeat (GAP) @(negedge clk);         // let the handshake close
    endtask

    task automatic wait_result(input int prev);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (res_count == prev && n < NORMAL_HOLD);
        if (res_count == prev) begin
            errors++;
            $display("no result_valid pulse arrived after the equal key");
        end
    endtask

    task automatic apply_row(input int i);
        string s;
        string h;
        byte   ch;
        int    k;
        int    prev;
        int    start;
        int    n_eq;
        s     = seq_tbl[i];
        h     = hold_tbl[i];
        n_eq  = 0;
        start = res_count;
        for (k = 0; k < s.len(); k++) begin
            ch   = s[k];
            prev = res_count;
            press_key(ch, hold_cycles(h[k]));
            if (h[k] != "s") model_step(ch); // short press must not count
            check("display_value", display_value, m_show_res ? m_result : m_entry);
            if (ch == "*" && h[k] != "s") begin
                n_eq++;
                wait_result(prev);
                check("result", res_seen, m_result);
                check("result", res_seen, exp_tbl[i]);
            end
        end
        @(posedge clk);
        check("result_valid count", 16'(res_count - start), 16'(n_eq));
    endtask

    initial begin
        int    a;
        int    b;
        int    total_keys;
        string s;
        string h;
        byte   op;
        key_down   = 1'b0;
        key_pos    = '0;
        m_entry    = '0;
        m_acc      = '0;
        m_result   = '0;
        m_pending  = 0;
        m_loaded   = 1'b0;
        m_show_res = 1'b0;
        void'($urandom(5));
        add_row("407*",     "nnnn",     16'd407);
        add_row("12A30*",   "nnnnnn",   16'd42);
        add_row("5B9*",     "nnnn",     16'hFFFC);
        add_row("2A3B1*",   "nnnnnn",   16'd4);
        add_row("123C45*",  "nnnnnnn",  16'd5535);
        add_row("300C300*", "nnnnnnnn", 16'h5F90);   // 90000 wraps
        add_row("8A2C3*",   "nnnnnn",   16'd30);
        add_row("7DA10*",   "nnnnnn",   16'd3);
        add_row("6#A2*",    "nnnnn",    16'd8);
        add_row("1D*",      "nnn",      16'hFFFF);
        add_row("53*",      "snn",      16'd3);      // 5 only bounces
        add_row("9*",       "ln",       16'd9);      // held long but entered once
        for (int r = 0; r < N_RANDOM; r++) begin
            a = $urandom % 1000;
            b = $urandom % 1000;
            case ($urandom % 3)
                0:       op = "A";
                1:       op = "B";
                default: op = "C";
            endcase
            s = $sformatf("%0d%c%0d*", a, op, b);
            h = "";
            for (int k = 0; k < s.len(); k++) h = {h, "n"};
            add_row(s, h, apply_op(op, 16'(a), 16'(b)));
        end
        total_keys = 0;
        for (int r = 0; r < n_rows; r++) total_keys += seq_tbl[r].len();
        wd_cycles = total_keys * (LONG_HOLD + GAP + calc_pkg::DEBOUNCE_CYCLES
                                  + calc_pkg::DATA_W + 20) + 20;
        table_ready = 1'b1;

        wait (nRST === 1'b1);
        @(negedge clk);
        check("result", result, '0);
        check("display_value", display_value, '0);
        check("result_valid", 16'(result_valid), '0);
        check("col_out", 16'(col_out), 16'(4'b1110));  // column 0 driven

        for (int r = 0; r < n_rows; r++) apply_row(r);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) $display("TEST RESULT: PASS");
        else $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: key sequences did not finish within %0d cycles", wd_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* build.f */
calc_pkg.sv
keypad_scanner.sv
calc_alu.sv
calc_controller.sv
calc_top.sv
tb_clock_gen.sv
keypad_model.sv
calc_tb.sv

/* Bender.yml */
package:
  name: keypad_calc

sources:
  - calc_pkg.sv
  - keypad_scanner.sv
  - calc_alu.sv
  - calc_controller.sv
  - calc_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - keypad_model.sv
      - calc_tb.sv
